// ==== hdl/eth_tx_pkg.sv ====
package eth_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [5:0]  hdr_idx_t;

    // frame layout
    localparam int HDR_BYTES      = 42;   // mac 14 + ip 20 + udp 8
    localparam int PREAMBLE_BYTES = 7;
    localparam byte_t PREAMBLE_OCTET = 8'h55;
    localparam byte_t SFD         = 8'hD5;
    localparam int MIN_PAYLOAD    = 18;   // 46 byte ethernet minimum less ip/udp headers
    localparam int FCS_BYTES      = 4;

    // protocol fields
    localparam logic [15:0] ETH_TYPE_IP = 16'h0800;
    localparam byte_t IP_VER_IHL        = 8'h45;
    localparam logic [15:0] IP_FLAGS_DF = 16'h4000;
    localparam byte_t IP_TTL            = 8'd64;
    localparam byte_t IP_PROTO_UDP      = 8'h11;
    localparam int IP_HDR_BYTES         = 20;
    localparam int UDP_HDR_BYTES        = 8;

    localparam logic [31:0] CRC32_POLY = 32'hEDB88320;   // 0x04C11DB7 reflected

    // payload buffer
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_AW    = 8;

endpackage

// ==== hdl/hdr_if.sv ====
interface hdr_if;

    logic                 hdr_start;   // one cycle, from sequencer
    logic                 hdr_ready;   // level, header stable
    eth_tx_pkg::hdr_idx_t hdr_idx;
    eth_tx_pkg::byte_t    hdr_byte;

    modport builder (
        input  hdr_start,
        input  hdr_idx,
        output hdr_ready,
        output hdr_byte
    );

    modport sequencer (
        output hdr_start,
        output hdr_idx,
        input  hdr_ready,
        input  hdr_byte
    );

endinterface

// ==== hdl/payload_fifo.sv ====
module payload_fifo (
    input  logic              clk,
    input  logic              rst,

    input  logic              wr_en,
    input  eth_tx_pkg::byte_t wr_data,
    output logic              full,

    input  logic              rd_en,
    output eth_tx_pkg::byte_t rd_data,
    output logic              empty
);

    eth_tx_pkg::byte_t mem [eth_tx_pkg::FIFO_DEPTH];

    logic [eth_tx_pkg::FIFO_AW:0] wr_ptr;   // top bit is the wrap flag
    logic [eth_tx_pkg::FIFO_AW:0] rd_ptr;
    logic                         wr_ok;
    logic                         rd_ok;

    assign full  = (wr_ptr[eth_tx_pkg::FIFO_AW] != rd_ptr[eth_tx_pkg::FIFO_AW]) &&
                   (wr_ptr[eth_tx_pkg::FIFO_AW-1:0] == rd_ptr[eth_tx_pkg::FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign wr_ok = wr_en && !full;   // drop writes when full
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok)
            mem[wr_ptr[eth_tx_pkg::FIFO_AW-1:0]] <= wr_data;
        if (rd_ok)
            rd_data <= mem[rd_ptr[eth_tx_pkg::FIFO_AW-1:0]];   // valid next cycle
    end

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("payload_fifo read while empty");

    a_full_write_dropped: assert property (
        @(posedge clk) disable iff (rst) (wr_en && full && !rd_en) |=> full
    ) else $error("payload_fifo write while full changed the fill level");

endmodule

// ==== hdl/hdr_builder.sv ====
module hdr_builder (
    input  logic                  clk,
    input  logic                  rst,

    hdr_if.builder                hdr,

    input  eth_tx_pkg::mac_addr_t src_mac_addr,
    input  eth_tx_pkg::mac_addr_t det_mac_addr,
    input  eth_tx_pkg::ip_addr_t  src_ip_addr,
    input  eth_tx_pkg::ip_addr_t  det_ip_addr,
    input  eth_tx_pkg::port_t     src_ip_port,
    input  eth_tx_pkg::port_t     det_ip_port,

    input  eth_tx_pkg::len_t      data_len
);

    typedef enum logic [1:0] {ST_IDLE, ST_SUM, ST_FOLD, ST_DONE} state_t;

    state_t                state;

    eth_tx_pkg::mac_addr_t src_mac;
    eth_tx_pkg::mac_addr_t det_mac;
    eth_tx_pkg::ip_addr_t  src_ip;
    eth_tx_pkg::ip_addr_t  det_ip;
    eth_tx_pkg::port_t     src_port;
    eth_tx_pkg::port_t     det_port;
    eth_tx_pkg::len_t      len;

    eth_tx_pkg::len_t      ip_len;
    eth_tx_pkg::len_t      udp_len;
    logic [19:0]           sum;     // ten words fit in 20 bits
    logic [15:0]           csum;
    logic [eth_tx_pkg::HDR_BYTES*8-1:0] hdr_vec;

    assign ip_len  = len + 16'(eth_tx_pkg::IP_HDR_BYTES + eth_tx_pkg::UDP_HDR_BYTES);
    assign udp_len = len + 16'(eth_tx_pkg::UDP_HDR_BYTES);

    always_ff @(posedge clk) begin
        if (hdr.hdr_start) begin
            src_mac  <= src_mac_addr;
            det_mac  <= det_mac_addr;
            src_ip   <= src_ip_addr;
            det_ip   <= det_ip_addr;
            src_port <= src_ip_port;
            det_port <= det_ip_port;
            len      <= data_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            hdr.hdr_ready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr.hdr_start) begin
                        hdr.hdr_ready <= 1'b0;
                        state         <= ST_SUM;
                    end
                end
                ST_SUM:  state <= ST_FOLD;
                ST_FOLD: state <= ST_DONE;
                default: begin
                    hdr.hdr_ready <= 1'b1;
                    state         <= ST_IDLE;
                end
            endcase
        end
    end

    // checksum datapath, id and checksum words are zero
    always_ff @(posedge clk) begin
        case (state)
            ST_SUM:  sum <= 20'({eth_tx_pkg::IP_VER_IHL, 8'h00}) + 20'(ip_len) +
                            20'(eth_tx_pkg::IP_FLAGS_DF) +
                            20'({eth_tx_pkg::IP_TTL, eth_tx_pkg::IP_PROTO_UDP}) +
                            20'(src_ip[31:16]) + 20'(src_ip[15:0]) +
                            20'(det_ip[31:16]) + 20'(det_ip[15:0]);
            ST_FOLD: sum <= 20'(sum[15:0]) + 20'(sum[19:16]);
            ST_DONE: csum <= ~(sum[15:0] + 16'(sum[16]));   // last carry and invert
            default: ;
        endcase
    end

    assign hdr_vec = {det_mac, src_mac, eth_tx_pkg::ETH_TYPE_IP,
                      eth_tx_pkg::IP_VER_IHL, 8'h00, ip_len, 16'h0000,
                      eth_tx_pkg::IP_FLAGS_DF, eth_tx_pkg::IP_TTL, eth_tx_pkg::IP_PROTO_UDP,
                      csum, src_ip, det_ip,
                      src_port, det_port, udp_len, 16'h0000};

    // byte 0 is the msb of the vector
    assign hdr.hdr_byte = (hdr.hdr_idx < eth_tx_pkg::HDR_BYTES) ?
        hdr_vec[(eth_tx_pkg::HDR_BYTES - 1 - int'(hdr.hdr_idx)) * 8 +: 8] : 8'h00;

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst) (state != ST_IDLE) |-> !hdr.hdr_start
    ) else $error("hdr_start while checksum in progress");

endmodule

// ==== hdl/crc32.sv ====
module crc32 (
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  logic              enable,
    input  eth_tx_pkg::byte_t din,
    output logic [31:0]       crc
);

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // lsb first, one bit per step
    always_comb begin
        crc_next = crc_reg;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ din[i])
                crc_next = (crc_next >> 1) ^ eth_tx_pkg::CRC32_POLY;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || init)
            crc_reg <= '1;
        else if (enable)
            crc_reg <= crc_next;
    end

    assign crc = ~crc_reg;   // byte 0 goes out first

endmodule

// ==== hdl/frame_tx.sv ====
module frame_tx (
    input  logic              clk,
    input  logic              rst,

    input  logic              fs,
    output logic              fd,
    input  eth_tx_pkg::len_t  data_len,

    hdr_if.sequencer          hdr,

    output logic              rd_en,
    input  eth_tx_pkg::byte_t rd_data,
    input  logic              empty,

    output eth_tx_pkg::byte_t txd,
    output logic              txen
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_WAIT_HDR, ST_PREAMBLE, ST_HEADER,
        ST_PAYLOAD, ST_PAD, ST_FCS, ST_DONE
    } state_t;

    state_t           state;
    eth_tx_pkg::len_t len;
    eth_tx_pkg::len_t cnt;     // byte index within current section
    logic             crc_init;
    logic             crc_en;
    logic [31:0]      crc;

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && fs)
            len <= data_len;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (fs)
                        state <= ST_WAIT_HDR;
                end
                ST_WAIT_HDR: begin
                    cnt <= '0;
                    if (hdr.hdr_ready)
                        state <= ST_PREAMBLE;
                end
                ST_PREAMBLE: begin
                    if (cnt == eth_tx_pkg::PREAMBLE_BYTES) begin   // sfd slot
                        state <= ST_HEADER;
                        cnt   <= '0;
                    end
                end
                ST_HEADER: begin
                    if (cnt == eth_tx_pkg::HDR_BYTES - 1) begin
                        state <= ST_PAYLOAD;
                        cnt   <= '0;
                    end
                end
                ST_PAYLOAD: begin
                    if (cnt == len - 1'b1) begin
                        if (len < eth_tx_pkg::MIN_PAYLOAD) begin
                            state <= ST_PAD;   // cnt keeps counting
                        end else begin
                            state <= ST_FCS;
                            cnt   <= '0;
                        end
                    end
                end
                ST_PAD: begin
                    if (cnt == eth_tx_pkg::MIN_PAYLOAD - 1) begin
                        state <= ST_FCS;
                        cnt   <= '0;
                    end
                end
                ST_FCS: begin
                    if (cnt == eth_tx_pkg::FCS_BYTES - 1)
                        state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_PREAMBLE: txd = (cnt < eth_tx_pkg::PREAMBLE_BYTES) ?
                               eth_tx_pkg::PREAMBLE_OCTET : eth_tx_pkg::SFD;
            ST_HEADER:   txd = hdr.hdr_byte;
            ST_PAYLOAD:  txd = rd_data;
            ST_FCS:      txd = crc[{cnt[1:0], 3'b000} +: 8];
            default:     txd = 8'h00;   // padding
        endcase
    end

    assign txen = state inside {ST_PREAMBLE, ST_HEADER, ST_PAYLOAD, ST_PAD, ST_FCS};
    assign fd   = (state == ST_DONE);

    assign hdr.hdr_start = (state == ST_IDLE) && fs;   // fields sampled with fs
    assign hdr.hdr_idx   = cnt[5:0];

    // prefetch so rd_data lands with the byte slot
    assign rd_en = ((state == ST_HEADER) && (cnt == eth_tx_pkg::HDR_BYTES - 1)) ||
                   ((state == ST_PAYLOAD) && (cnt < len - 1'b1));

    assign crc_init = (state == ST_PREAMBLE);
    assign crc_en   = state inside {ST_HEADER, ST_PAYLOAD, ST_PAD};

    crc32
    crc32_dut(
        .clk(clk),
        .rst(rst),
        .init(crc_init),
        .enable(crc_en),
        .din(txd),
        .crc(crc)
    );

    a_txen_whole_frame: assert property (
        @(posedge clk) disable iff (rst) $fell(txen) |-> fd
    ) else $error("txen dropped before end of frame");

    a_no_underrun: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> !empty
    ) else $error("payload fifo underrun");

endmodule

// ==== hdl/udp_tx_top.sv ====
module udp_tx_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  fs,
    output logic                  fd,

    input  eth_tx_pkg::mac_addr_t src_mac_addr,
    input  eth_tx_pkg::mac_addr_t det_mac_addr,
    input  eth_tx_pkg::ip_addr_t  src_ip_addr,
    input  eth_tx_pkg::ip_addr_t  det_ip_addr,
    input  eth_tx_pkg::port_t     src_ip_port,
    input  eth_tx_pkg::port_t     det_ip_port,

    input  eth_tx_pkg::len_t      data_len,

    input  logic                  wr_en,
    input  eth_tx_pkg::byte_t     wr_data,
    output logic                  full,

    output eth_tx_pkg::byte_t     txd,
    output logic                  txen
);

    logic              rd_en;
    eth_tx_pkg::byte_t rd_data;
    logic              empty;

    hdr_if hdr();

    payload_fifo
    payload_fifo_dut(
        .clk(clk),
        .rst(rst),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .full(full),
        .rd_en(rd_en),
        .rd_data(rd_data),
        .empty(empty)
    );

    hdr_builder
    hdr_builder_dut(
        .clk(clk),
        .rst(rst),
        .hdr(hdr.builder),
        .src_mac_addr(src_mac_addr),
        .det_mac_addr(det_mac_addr),
        .src_ip_addr(src_ip_addr),
        .det_ip_addr(det_ip_addr),
        .src_ip_port(src_ip_port),
        .det_ip_port(det_ip_port),   // real destination port
        .data_len(data_len)
    );

    frame_tx
    frame_tx_dut(
        .clk(clk),
        .rst(rst),
        .fs(fs),
        .fd(fd),
        .data_len(data_len),
        .hdr(hdr.sequencer),
        .rd_en(rd_en),
        .rd_data(rd_data),
        .empty(empty),
        .txd(txd),
        .txen(txen)
    );

endmodule

// ==== sim/udp_tx_tb.sv ====
module udp_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef eth_tx_pkg::byte_t byte_q_t[$];

    localparam int CLK_NS = 4;

    logic                  clk;
    logic                  rst;
    logic                  fs;
    logic                  fd;
    eth_tx_pkg::mac_addr_t src_mac_addr;
    eth_tx_pkg::mac_addr_t det_mac_addr;
    eth_tx_pkg::ip_addr_t  src_ip_addr;
    eth_tx_pkg::ip_addr_t  det_ip_addr;
    eth_tx_pkg::port_t     src_ip_port;
    eth_tx_pkg::port_t     det_ip_port;
    eth_tx_pkg::len_t      data_len;
    logic                  wr_en;
    eth_tx_pkg::byte_t     wr_data;
    logic                  full;
    eth_tx_pkg::byte_t     txd;
    logic                  txen;

    logic [31:0] lfsr = 32'd69;
    int          plan_lens[$] = '{5, 40, 100, 256, 30, 20, 256};   // payload per frame
    byte_q_t     fifo_model;        // bytes written and not yet framed
    byte_q_t     exp_bytes;
    int          exp_lens[$];
    byte_q_t     cap_bytes;
    int          cap_lens[$];
    byte_q_t     cur_frame;
    logic        in_frame = 1'b0;
    int          frames_expected = 0;
    int          frames_captured = 0;
    int          frames_checked = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    udp_tx_top DUT (
        .clk(clk), .rst(rst), .fs(fs), .fd(fd),
        .src_mac_addr(src_mac_addr), .det_mac_addr(det_mac_addr),
        .src_ip_addr(src_ip_addr), .det_ip_addr(det_ip_addr),
        .src_ip_port(src_ip_port), .det_ip_port(det_ip_port),
        .data_len(data_len), .wr_en(wr_en), .wr_data(wr_data), .full(full),
        .txd(txd), .txen(txen)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [63:0] random_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    function automatic int frame_bytes(int len);
        int pl;
        pl = (len < eth_tx_pkg::MIN_PAYLOAD) ? eth_tx_pkg::MIN_PAYLOAD : len;
        return 8 + eth_tx_pkg::HDR_BYTES + pl + 4;
    endfunction

    function automatic void push_be(ref byte_q_t q, input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--)
            q.push_back(v[i*8 +: 8]);
    endfunction

    // ones' complement sum of 16-bit words with end-around carry
    function automatic logic [15:0] ones_sum(byte_q_t q, int first, int words);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < words; i++)
            s = s + {q[first + 2*i], q[first + 2*i + 1]};
        while (s[31:16] != 0)
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        return s[15:0];
    endfunction

    // msb-first crc with reflected input and output
    function automatic logic [31:0] fcs_of(byte_q_t q, int first);
        logic [31:0] c;
        logic [31:0] r;
        logic [7:0]  rb;
        c = '1;
        for (int i = first; i < q.size(); i++) begin
            for (int b = 0; b < 8; b++)
                rb[b] = q[i][7-b];
            c = c ^ {rb, 24'h0};
            for (int b = 0; b < 8; b++)
                c = c[31] ? ((c << 1) ^ 32'h04C11DB7) : (c << 1);
        end
        for (int b = 0; b < 32; b++)
            r[b] = c[31-b];
        return ~r;
    endfunction

    function automatic byte_q_t expected_frame(
        eth_tx_pkg::mac_addr_t smac, eth_tx_pkg::mac_addr_t dmac,
        eth_tx_pkg::ip_addr_t sip, eth_tx_pkg::ip_addr_t dip,
        eth_tx_pkg::port_t sport, eth_tx_pkg::port_t dport, byte_q_t pl);
        byte_q_t     f;
        byte_q_t     ip_hdr;
        logic [15:0] csum;
        logic [31:0] fcs;
        int          plen;
        plen = pl.size();
        for (int i = 0; i < 7; i++)
            f.push_back(8'h55);
        f.push_back(8'hD5);
        push_be(f, dmac, 6);
        push_be(f, smac, 6);
        push_be(f, 16'h0800, 2);
        push_be(ip_hdr, 16'h4500, 2);
        push_be(ip_hdr, plen + 28, 2);
        push_be(ip_hdr, 16'h0000, 2);   // id
        push_be(ip_hdr, 16'h4000, 2);   // don't fragment
        push_be(ip_hdr, {8'd64, 8'h11}, 2);
        push_be(ip_hdr, 16'h0000, 2);
        push_be(ip_hdr, sip, 4);
        push_be(ip_hdr, dip, 4);
        csum = ~ones_sum(ip_hdr, 0, 10);
        ip_hdr[10] = csum[15:8];
        ip_hdr[11] = csum[7:0];
        foreach (ip_hdr[i])
            f.push_back(ip_hdr[i]);
        push_be(f, sport, 2);
        push_be(f, dport, 2);
        push_be(f, plen + 8, 2);
        push_be(f, 16'h0000, 2);        // udp checksum unused
        foreach (pl[i])
            f.push_back(pl[i]);
        while (f.size() < 8 + 42 + 18)
            f.push_back(8'h00);
        fcs = fcs_of(f, 8);
        for (int i = 0; i < 4; i++)
            f.push_back(fcs[i*8 +: 8]);
        return f;
    endfunction

    // capture on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (txen) begin
                cur_frame.push_back(txd);
                in_frame = 1'b1;
                assert (fd === 1'b0) else begin
                    $display("[ERROR] fd expected 0 actual %h while txen high", fd);
                    errors++;
                end
            end else if (in_frame) begin
                assert (fd === 1'b1) else begin
                    $display("[ERROR] fd expected 1 actual %h after txen fell", fd);
                    errors++;
                end
                cap_lens.push_back(cur_frame.size());
                foreach (cur_frame[i])
                    cap_bytes.push_back(cur_frame[i]);
                cur_frame.delete();
                in_frame = 1'b0;
                frames_captured++;
            end else begin
                assert (fd === 1'b0) else begin
                    $display("[ERROR] fd expected 0 actual %h outside a frame", fd);
                    errors++;
                end
            end
        end
    end

    task automatic check_frame();
        int          got_len;
        int          exp_len;
        byte_q_t     got;
        byte_q_t     want;
        logic [15:0] ip_sum;
        got_len = cap_lens.pop_front();
        for (int i = 0; i < got_len; i++)
            got.push_back(cap_bytes.pop_front());
        assert (exp_lens.size() != 0) else begin
            $display("a frame of %0d bytes was sent with no frame expected", got_len);
            errors++;
        end
        if (exp_lens.size() != 0) begin
            exp_len = exp_lens.pop_front();
            for (int i = 0; i < exp_len; i++)
                want.push_back(exp_bytes.pop_front());
            assert (got_len == exp_len) else begin
                $display("[ERROR] txen length expected %h actual %h", exp_len, got_len);
                errors++;
            end
            if (got_len == exp_len) begin
                foreach (want[i]) begin
                    assert (got[i] === want[i]) else begin
                        $display("[ERROR] txd index %0d expected %h actual %h",
                                 i, want[i], got[i]);
                        errors++;
                    end
                end
            end
            if (got_len >= 8 + 34) begin
                ip_sum = ones_sum(got, 22, 10);   // ip header starts at byte 22
                assert (ip_sum == 16'hFFFF) else begin
                    $display("[ERROR] ip header sum expected ffff actual %h", ip_sum);
                    errors++;
                end
            end
        end
        frames_checked++;
    endtask

    always @(posedge clk) begin
        if (cap_lens.size() != 0)
            check_frame();
    end

    task automatic write_payload(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            wr_en   = 1'b1;
            wr_data = eth_tx_pkg::byte_t'(random_bits(8));
            if (fifo_model.size() < eth_tx_pkg::FIFO_DEPTH)
                fifo_model.push_back(wr_data);   // else dropped
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic send_frame(int n);
        byte_q_t pl;
        byte_q_t f;
        eth_tx_pkg::mac_addr_t smac;
        eth_tx_pkg::mac_addr_t dmac;
        eth_tx_pkg::ip_addr_t  sip;
        eth_tx_pkg::ip_addr_t  dip;
        eth_tx_pkg::port_t     sport;
        eth_tx_pkg::port_t     dport;
        smac  = eth_tx_pkg::mac_addr_t'(random_bits(48));
        dmac  = eth_tx_pkg::mac_addr_t'(random_bits(48));
        sip   = eth_tx_pkg::ip_addr_t'(random_bits(32));
        dip   = eth_tx_pkg::ip_addr_t'(random_bits(32));
        sport = eth_tx_pkg::port_t'(random_bits(16));
        dport = eth_tx_pkg::port_t'(random_bits(16));
        for (int i = 0; i < n; i++)
            pl.push_back(fifo_model.pop_front());
        f = expected_frame(smac, dmac, sip, dip, sport, dport, pl);
        exp_lens.push_back(f.size());
        foreach (f[i])
            exp_bytes.push_back(f[i]);
        frames_expected++;
        @(posedge clk);
        #1;
        src_mac_addr = smac;
        det_mac_addr = dmac;
        src_ip_addr  = sip;
        det_ip_addr  = dip;
        src_ip_port  = sport;
        det_ip_port  = dport;
        data_len     = eth_tx_pkg::len_t'(n);
        fs           = 1'b1;
        @(posedge clk);
        #1;
        fs = 1'b0;
    endtask

    task automatic wait_frames();
        while (frames_checked < frames_expected)
            @(negedge clk);
    endtask

    task automatic expect_bit(string name, logic got, logic want);
        assert (got === want) else begin
            $display("[ERROR] %s expected %h actual %h", name, want, got);
            errors++;
        end
    endtask

    task automatic end_test(string name, int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int e0;
        rst = 1'b1;
        fs = 1'b0;
        wr_en = 1'b0;
        wr_data = '0;
        data_len = '0;
        src_mac_addr = '0;
        det_mac_addr = '0;
        src_ip_addr = '0;
        det_ip_addr = '0;
        src_ip_port = '0;
        det_ip_port = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        @(negedge clk);
        expect_bit("txen", txen, 1'b0);
        expect_bit("fd", fd, 1'b0);
        expect_bit("full", full, 1'b0);
        end_test("reset state", e0);

        e0 = errors;
        write_payload(5);
        send_frame(5);
        wait_frames();
        end_test("short payload with padding", e0);

        e0 = errors;
        write_payload(40);
        send_frame(40);
        wait_frames();
        write_payload(100);
        send_frame(100);
        wait_frames();
        write_payload(256);
        send_frame(256);
        wait_frames();
        end_test("random payloads 40 100 256", e0);

        e0 = errors;
        write_payload(30);
        write_payload(20);
        send_frame(30);
        wait_frames();
        send_frame(20);
        while (!txen)
            @(negedge clk);
        repeat (5) @(posedge clk);
        #1;
        data_len = 16'd7;   // must be ignored
        fs = 1'b1;
        @(posedge clk);
        #1;
        fs = 1'b0;
        wait_frames();
        repeat (30) @(negedge clk);
        assert (frames_captured == frames_expected && !in_frame) else begin
            $display("an fs pulse during a frame started an extra frame");
            errors++;
        end
        end_test("back to back frames and busy fs", e0);

        e0 = errors;
        write_payload(eth_tx_pkg::FIFO_DEPTH);
        @(negedge clk);
        expect_bit("full", full, 1'b1);
        write_payload(1);   // dropped
        @(negedge clk);
        expect_bit("full", full, 1'b1);
        send_frame(eth_tx_pkg::FIFO_DEPTH);
        wait_frames();
        end_test("full fifo drops extra write", e0);

        $display("tests passed %0d failed %0d, frames checked %0d",
                 tests_passed, tests_failed, frames_checked);
        if (tests_failed == 0 && errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // frame bytes, write cycles and 100 cycles slack per frame
    initial begin
        int budget;
        budget = 0;
        foreach (plan_lens[i])
            budget += frame_bytes(plan_lens[i]) + plan_lens[i] + 100;
        repeat (budget) @(posedge clk);
        $display("timeout after %0d cycles, frames did not complete", budget);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/eth_tx_pkg.sv
hdl/hdr_if.sv
hdl/payload_fifo.sv
hdl/hdr_builder.sv
hdl/crc32.sv
hdl/frame_tx.sv
hdl/udp_tx_top.sv
sim/udp_tx_tb.sv
